/* logic/dma_pkg.sv */
package dma_pkg;

    // Bus widths
    localparam int addr_w = 32;
    localparam int data_w = 64;
    localparam int len_w  = 8;    // AXI4 LEN field

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [len_w-1:0]  len_t;   // Beats minus one
    typedef logic [1:0]        resp_t;

    // --------------------
    // Beat buffer sizing
    // --------------------
    localparam int fifo_depth = 16;
    localparam int fifo_ptr_w = 4;      // log2 of fifo_depth

    // --------------------
    // AXI encodings
    // --------------------
    localparam logic [2:0] axi_size_beat  = 3'd3;   // 8 bytes per beat
    localparam logic [1:0] axi_burst_incr = 2'd1;   // INCR
    localparam resp_t      resp_okay      = 2'b00;

    // Job controller state
    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } ctrl_state_t;

endpackage

/* logic/copy_control.sv */
`timescale 1ns/10ps

module copy_control (
    input  logic                M_AXI_ACLK,
    input  logic                rst,
    input  logic                start,
    input  dma_pkg::addr_t      src_addr,
    input  dma_pkg::addr_t      dst_addr,
    input  dma_pkg::len_t       burst_len,
    input  logic                rd_done,    // Reader finished pulse
    input  logic                rd_err,     // Valid with rd_done
    input  logic                wr_done,    // Writer finished pulse
    input  logic                wr_err,     // Valid with wr_done
    output logic                go,
    output dma_pkg::addr_t      job_src,
    output dma_pkg::addr_t      job_dst,
    output dma_pkg::len_t       job_len,
    output logic                busy,
    output logic                done,
    output logic                irq,
    output logic                error
);

    dma_pkg::ctrl_state_t state;
    logic                 rd_fin;     // Reader already reported
    logic                 wr_fin;     // Writer already reported
    logic                 all_fin;

    // Start only counts outside a running job
    assign go      = start && (state != dma_pkg::st_busy);
    // Pulses may land in either order, or together
    assign all_fin = (rd_fin || rd_done) && (wr_fin || wr_done);

    assign busy = (state == dma_pkg::st_busy);
    assign done = (state == dma_pkg::st_done);   // Held until next go

    // --------------------
    // Job registers
    // --------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (go) begin
            job_src <= src_addr;
            job_dst <= dst_addr;
            job_len <= burst_len;
        end
    end

    // --------------------
    // Job FSM
    // --------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            state  <= dma_pkg::st_idle;
            rd_fin <= 1'b0;
            wr_fin <= 1'b0;
            irq    <= 1'b0;
            error  <= 1'b0;
        end else begin
            irq <= 1'b0;                            // Single-cycle by default
            if (go) begin
                state  <= dma_pkg::st_busy;
                rd_fin <= 1'b0;
                wr_fin <= 1'b0;
                error  <= 1'b0;                     // Fresh job, fresh flag
            end else if (state == dma_pkg::st_busy) begin
                if (rd_done) rd_fin <= 1'b1;
                if (wr_done) wr_fin <= 1'b1;
                // Sticky over the job
                if ((rd_done && rd_err) || (wr_done && wr_err)) error <= 1'b1;
                if (all_fin) begin
                    state <= dma_pkg::st_done;
                    irq   <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/burst_reader.sv */
`timescale 1ns/10ps

module burst_reader (
    input  logic                M_AXI_ACLK,
    input  logic                rst,
    input  logic                go,
    input  dma_pkg::addr_t      job_src,
    input  dma_pkg::len_t       job_len,
    // AR channel
    input  logic                arready,
    output logic                arvalid,
    output dma_pkg::addr_t      araddr,
    output dma_pkg::len_t       arlen,
    // R channel
    input  logic                rvalid,
    input  dma_pkg::data_t      rdata,
    input  dma_pkg::resp_t      rresp,
    input  logic                rlast,
    output logic                rready,
    // Beat FIFO push side
    input  logic                fifo_in_ready,
    output logic                fifo_in_valid,
    output dma_pkg::data_t      fifo_in_data,
    // Status to controller
    output logic                rd_done,
    output logic                rd_err
);

    logic ar_pend;     // AR not yet accepted
    logic rd_active;   // Burst in progress until rlast
    logic beat_acc;

    // Request fields come straight from the latched job
    assign araddr  = job_src;
    assign arlen   = job_len;
    assign arvalid = ar_pend;

    // R straight into the FIFO, only while a burst is open
    assign rready        = fifo_in_ready && rd_active;
    assign fifo_in_valid = rvalid && rd_active;
    assign fifo_in_data  = rdata;
    assign beat_acc      = rvalid && rready;

    // --------------------
    // Burst tracking
    // --------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            ar_pend   <= 1'b0;
            rd_active <= 1'b0;
            rd_done   <= 1'b0;
            rd_err    <= 1'b0;
        end else begin
            rd_done <= beat_acc && rlast;           // Cycle after last beat
            if (go) begin
                ar_pend   <= 1'b1;
                rd_active <= 1'b1;
                rd_err    <= 1'b0;
            end else begin
                if (arvalid && arready) ar_pend <= 1'b0;   // Held until taken
                if (beat_acc && rlast) rd_active <= 1'b0;
                if (beat_acc && (rresp != dma_pkg::resp_okay)) begin
                    rd_err <= 1'b1;                 // Any bad beat marks the burst
                end
            end
        end
    end

endmodule

/* logic/beat_fifo.sv */
`timescale 1ns/10ps

module beat_fifo (
    input  logic                M_AXI_ACLK,
    input  logic                rst,
    // Push side
    input  logic                in_valid,
    input  dma_pkg::data_t      in_data,
    output logic                in_ready,
    // Pop side
    input  logic                out_ready,
    output logic                out_valid,
    output dma_pkg::data_t      out_data
);

    dma_pkg::data_t               mem [dma_pkg::fifo_depth];
    logic [dma_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [dma_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [dma_pkg::fifo_ptr_w:0]   count;   // One extra bit for full
    logic                         full;
    logic                         push;
    logic                         pop;

    assign full      = count[dma_pkg::fifo_ptr_w];   // Depth is a power of two
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];                  // Head of queue
    // A pop frees a slot in the same cycle
    assign in_ready  = !full || out_ready;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Storage
    always_ff @(posedge M_AXI_ACLK) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
        end
    end

endmodule

/* logic/burst_writer.sv */
`timescale 1ns/10ps

module burst_writer (
    input  logic                M_AXI_ACLK,
    input  logic                rst,
    input  logic                go,
    input  dma_pkg::addr_t      job_dst,
    input  dma_pkg::len_t       job_len,
    // AW channel
    input  logic                awready,
    output logic                awvalid,
    output dma_pkg::addr_t      awaddr,
    output dma_pkg::len_t       awlen,
    // W channel
    input  logic                wready,
    output logic                wvalid,
    output dma_pkg::data_t      wdata,
    output logic                wlast,
    // B channel
    input  logic                bvalid,
    input  dma_pkg::resp_t      bresp,
    output logic                bready,
    // Beat FIFO pop side
    input  logic                fifo_out_valid,
    input  dma_pkg::data_t      fifo_out_data,
    output logic                fifo_out_ready,
    // Status to controller
    output logic                wr_done,
    output logic                wr_err
);

    typedef enum logic [1:0] {
        wr_idle,
        wr_aw,       // Address out, waiting on awready
        wr_data,     // Streaming beats
        wr_resp      // Waiting on B
    } wr_state_t;

    wr_state_t      state;
    dma_pkg::len_t  beat_cnt;    // Accepted W beats this burst
    logic           beat_acc;
    logic           b_acc;

    assign awaddr  = job_dst;
    assign awlen   = job_len;
    assign awvalid = (state == wr_aw);

    // Beats flow only after AW is accepted
    assign wvalid         = (state == wr_data) && fifo_out_valid;
    assign wdata          = fifo_out_data;
    assign wlast          = (state == wr_data) && (beat_cnt == job_len);
    assign fifo_out_ready = wvalid && wready;   // Pop on W handshake
    assign beat_acc       = fifo_out_ready;

    assign bready = (state == wr_resp);
    assign b_acc  = bvalid && bready;

    // --------------------
    // Write sequence
    // --------------------
    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            state    <= wr_idle;
            beat_cnt <= '0;
            wr_done  <= 1'b0;
            wr_err   <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            case (state)
                wr_idle: begin
                    if (go) begin
                        state    <= wr_aw;
                        beat_cnt <= '0;
                        wr_err   <= 1'b0;
                    end
                end
                wr_aw: begin
                    if (awready) state <= wr_data;      // awvalid is high here
                end
                wr_data: begin
                    if (beat_acc) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast) state <= wr_resp;    // Last beat taken
                    end
                end
                wr_resp: begin
                    if (b_acc) begin
                        state   <= wr_idle;
                        wr_done <= 1'b1;                // Cycle after B
                        wr_err  <= (bresp != dma_pkg::resp_okay);
                    end
                end
                default: state <= wr_idle;
            endcase
        end
    end

endmodule

/* logic/dma_copy_top.sv */
`timescale 1ns/10ps

module dma_copy_top (
    input  logic                                  M_AXI_ACLK,
    input  logic                                  rst,
    // Job interface
    input  logic                                  start,
    input  dma_pkg::addr_t                        src_addr,
    input  dma_pkg::addr_t                        dst_addr,
    input  dma_pkg::len_t                         burst_len,
    output logic                                  busy,
    output logic                                  done,
    output logic                                  irq,
    output logic                                  error,
    // --------------------
    // AR channel
    // --------------------
    output dma_pkg::addr_t                        M_AXI_ARADDR,
    output dma_pkg::len_t                         M_AXI_ARLEN,
    output logic [2:0]                            M_AXI_ARSIZE,
    output logic [1:0]                            M_AXI_ARBURST,
    output logic                                  M_AXI_ARVALID,
    input  logic                                  M_AXI_ARREADY,
    // R channel
    input  dma_pkg::data_t                        M_AXI_RDATA,
    input  dma_pkg::resp_t                        M_AXI_RRESP,
    input  logic                                  M_AXI_RLAST,
    input  logic                                  M_AXI_RVALID,
    output logic                                  M_AXI_RREADY,
    // --------------------
    // AW channel
    // --------------------
    output dma_pkg::addr_t                        M_AXI_AWADDR,
    output dma_pkg::len_t                         M_AXI_AWLEN,
    output logic [2:0]                            M_AXI_AWSIZE,
    output logic [1:0]                            M_AXI_AWBURST,
    output logic                                  M_AXI_AWVALID,
    input  logic                                  M_AXI_AWREADY,
    // W channel
    output dma_pkg::data_t                        M_AXI_WDATA,
    output logic [dma_pkg::data_w/8-1:0]          M_AXI_WSTRB,
    output logic                                  M_AXI_WLAST,
    output logic                                  M_AXI_WVALID,
    input  logic                                  M_AXI_WREADY,
    // B channel
    input  dma_pkg::resp_t                        M_AXI_BRESP,
    input  logic                                  M_AXI_BVALID,
    output logic                                  M_AXI_BREADY
);

    // Controller to engines
    logic             go;
    dma_pkg::addr_t   job_src;
    dma_pkg::addr_t   job_dst;
    dma_pkg::len_t    job_len;
    logic             rd_done;
    logic             rd_err;
    logic             wr_done;
    logic             wr_err;

    // Reader to FIFO to writer
    logic             fifo_in_valid;
    logic             fifo_in_ready;
    dma_pkg::data_t   fifo_in_data;
    logic             fifo_out_valid;
    logic             fifo_out_ready;
    dma_pkg::data_t   fifo_out_data;

    // Fixed burst attributes, full 64-bit beats
    assign M_AXI_ARSIZE  = dma_pkg::axi_size_beat;
    assign M_AXI_ARBURST = dma_pkg::axi_burst_incr;
    assign M_AXI_AWSIZE  = dma_pkg::axi_size_beat;
    assign M_AXI_AWBURST = dma_pkg::axi_burst_incr;
    assign M_AXI_WSTRB   = '1;                       // Every byte written

    copy_control u_ctrl (
        .M_AXI_ACLK (M_AXI_ACLK),
        .rst        (rst),
        .start      (start),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .burst_len  (burst_len),
        .rd_done    (rd_done),
        .rd_err     (rd_err),
        .wr_done    (wr_done),
        .wr_err     (wr_err),
        .go         (go),
        .job_src    (job_src),
        .job_dst    (job_dst),
        .job_len    (job_len),
        .busy       (busy),
        .done       (done),
        .irq        (irq),
        .error      (error)
    );

    burst_reader u_reader (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .rst           (rst),
        .go            (go),
        .job_src       (job_src),
        .job_len       (job_len),
        .arready       (M_AXI_ARREADY),
        .arvalid       (M_AXI_ARVALID),
        .araddr        (M_AXI_ARADDR),
        .arlen         (M_AXI_ARLEN),
        .rvalid        (M_AXI_RVALID),
        .rdata         (M_AXI_RDATA),
        .rresp         (M_AXI_RRESP),
        .rlast         (M_AXI_RLAST),
        .rready        (M_AXI_RREADY),
        .fifo_in_ready (fifo_in_ready),
        .fifo_in_valid (fifo_in_valid),
        .fifo_in_data  (fifo_in_data),
        .rd_done       (rd_done),
        .rd_err        (rd_err)
    );

    // Lets reads run ahead of the write burst
    beat_fifo u_fifo (
        .M_AXI_ACLK (M_AXI_ACLK),
        .rst        (rst),
        .in_valid   (fifo_in_valid),
        .in_data    (fifo_in_data),
        .in_ready   (fifo_in_ready),
        .out_ready  (fifo_out_ready),
        .out_valid  (fifo_out_valid),
        .out_data   (fifo_out_data)
    );

    burst_writer u_writer (
        .M_AXI_ACLK     (M_AXI_ACLK),
        .rst            (rst),
        .go             (go),
        .job_dst        (job_dst),
        .job_len        (job_len),
        .awready        (M_AXI_AWREADY),
        .awvalid        (M_AXI_AWVALID),
        .awaddr         (M_AXI_AWADDR),
        .awlen          (M_AXI_AWLEN),
        .wready         (M_AXI_WREADY),
        .wvalid         (M_AXI_WVALID),
        .wdata          (M_AXI_WDATA),
        .wlast          (M_AXI_WLAST),
        .bvalid         (M_AXI_BVALID),
        .bresp          (M_AXI_BRESP),
        .bready         (M_AXI_BREADY),
        .fifo_out_valid (fifo_out_valid),
        .fifo_out_data  (fifo_out_data),
        .fifo_out_ready (fifo_out_ready),
        .wr_done        (wr_done),
        .wr_err         (wr_err)
    );

endmodule

/* testbench/axi_mem_model.sv */
`timescale 1ns/10ps

module axi_mem_model (
    input  logic                M_AXI_ACLK,
    input  logic                rst,
    input  logic                stall_en,   // Random stalls on every channel
    input  int                  err_beat,   // Read beat index given SLVERR, -1 for none
    input  logic                b_err,      // SLVERR on the write response
    // Read address and data
    input  dma_pkg::addr_t      araddr,
    input  dma_pkg::len_t       arlen,
    input  logic                arvalid,
    output logic                arready,
    output dma_pkg::data_t      rdata,
    output dma_pkg::resp_t      rresp,
    output logic                rlast,
    output logic                rvalid,
    input  logic                rready,
    // Write address, data and response
    input  logic                awvalid,
    output logic                awready,
    input  logic                wvalid,
    input  logic                wlast,
    output logic                wready,
    output dma_pkg::resp_t      bresp,
    output logic                bvalid,
    input  logic                bready
);

    localparam logic [15:0]    lfsr_poly   = 16'hB400;   // x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0]    lfsr_seed   = 16'd9777;
    localparam dma_pkg::resp_t resp_slverr = 2'b10;

    logic [15:0]    lfsr;
    logic           rd_act;     // AR taken, beats still owed
    logic           wr_act;     // AW taken, waiting for wlast
    logic           b_pend;     // Response owed
    dma_pkg::addr_t rd_addr;
    dma_pkg::len_t  rd_len;
    int             rd_cnt;     // Next beat index to present

    // Source contents, a fixed rule of the beat address
    function automatic dma_pkg::data_t src_word(input dma_pkg::addr_t a);
        return {a ^ 32'h5a3c_96e1, a ^ 32'h5a3c_96e1};
    endfunction

    // Galois shift, taps folded in when the low bit falls out
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_poly) : (s >> 1);
    endfunction

    // One LFSR step per stall decision
    task automatic stall_bit(output logic b);
        b = 1'b0;
        if (stall_en) begin
            b    = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    always @(posedge M_AXI_ACLK) begin
        logic s;
        if (rst) begin
            lfsr = lfsr_seed;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rresp   <= dma_pkg::resp_okay;
            rdata   <= '0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= dma_pkg::resp_okay;
            rd_act  <= 1'b0;
            wr_act  <= 1'b0;
            b_pend  <= 1'b0;
            rd_cnt  <= 0;
        end else begin
            // --------------------
            // Read side
            // --------------------
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_act  <= 1'b1;
                rd_addr <= araddr;
                rd_len  <= arlen;
                rd_cnt  <= 0;
            end else if (arvalid && !rd_act) begin
                stall_bit(s);
                arready <= !s;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                if (rlast) rd_act <= 1'b0;        // Burst drained
            end
            // Slot is free, or frees now and more beats follow
            if (rd_act && (!rvalid || (rready && !rlast))) begin
                stall_bit(s);
                if (!s) begin
                    rvalid  <= 1'b1;
                    rdata   <= src_word(rd_addr);
                    rresp   <= (rd_cnt == err_beat) ? resp_slverr : dma_pkg::resp_okay;
                    rlast   <= (rd_cnt == int'(rd_len));
                    rd_addr <= rd_addr + 32'd8;
                    rd_cnt  <= rd_cnt + 1;
                end
            end
            // --------------------
            // Write side
            // --------------------
            if (awvalid && awready) begin
                awready <= 1'b0;
                wr_act  <= 1'b1;
            end else if (awvalid && !wr_act && !b_pend) begin
                stall_bit(s);
                awready <= !s;
            end
            if (wvalid && wready && wlast) begin
                wr_act <= 1'b0;
                b_pend <= 1'b1;
            end
            if (wr_act && !(wvalid && wready && wlast)) begin
                stall_bit(s);
                wready <= !s;
            end else begin
                wready <= 1'b0;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
            end else if (b_pend && !bvalid) begin
                stall_bit(s);
                if (!s) begin
                    bvalid <= 1'b1;
                    bresp  <= b_err ? resp_slverr : dma_pkg::resp_okay;
                end
            end
        end
    end

endmodule

/* testbench/tb_dma_copy.sv */
`timescale 1ns/10ps

module tb_dma_copy;

    localparam int total_beats = 4 + 32 + 8 + 6;     // Beats over all four jobs
    localparam int cycle_limit = 80 * total_beats;   // Generous for half-rate stalls

    logic                          M_AXI_ACLK;
    logic                          rst;
    logic                          start;
    dma_pkg::addr_t                src_addr;
    dma_pkg::addr_t                dst_addr;
    dma_pkg::len_t                 burst_len;
    logic                          busy;
    logic                          done;
    logic                          irq;
    logic                          error;
    dma_pkg::addr_t                M_AXI_ARADDR;
    dma_pkg::len_t                 M_AXI_ARLEN;
    logic [2:0]                    M_AXI_ARSIZE;
    logic [1:0]                    M_AXI_ARBURST;
    logic                          M_AXI_ARVALID;
    logic                          M_AXI_ARREADY;
    dma_pkg::data_t                M_AXI_RDATA;
    dma_pkg::resp_t                M_AXI_RRESP;
    logic                          M_AXI_RLAST;
    logic                          M_AXI_RVALID;
    logic                          M_AXI_RREADY;
    dma_pkg::addr_t                M_AXI_AWADDR;
    dma_pkg::len_t                 M_AXI_AWLEN;
    logic [2:0]                    M_AXI_AWSIZE;
    logic [1:0]                    M_AXI_AWBURST;
    logic                          M_AXI_AWVALID;
    logic                          M_AXI_AWREADY;
    dma_pkg::data_t                M_AXI_WDATA;
    logic [dma_pkg::data_w/8-1:0]  M_AXI_WSTRB;
    logic                          M_AXI_WLAST;
    logic                          M_AXI_WVALID;
    logic                          M_AXI_WREADY;
    dma_pkg::resp_t                M_AXI_BRESP;
    logic                          M_AXI_BVALID;
    logic                          M_AXI_BREADY;

    // Slave behavior per job
    logic stall_en;
    int   err_beat;
    logic b_err;

    int checks = 0;
    int errors = 0;
    int cycles = 0;

    dma_copy_top DUT (.*);

    axi_mem_model mem (
        .M_AXI_ACLK (M_AXI_ACLK),
        .rst        (rst),
        .stall_en   (stall_en),
        .err_beat   (err_beat),
        .b_err      (b_err),
        .araddr     (M_AXI_ARADDR),
        .arlen      (M_AXI_ARLEN),
        .arvalid    (M_AXI_ARVALID),
        .arready    (M_AXI_ARREADY),
        .rdata      (M_AXI_RDATA),
        .rresp      (M_AXI_RRESP),
        .rlast      (M_AXI_RLAST),
        .rvalid     (M_AXI_RVALID),
        .rready     (M_AXI_RREADY),
        .awvalid    (M_AXI_AWVALID),
        .awready    (M_AXI_AWREADY),
        .wvalid     (M_AXI_WVALID),
        .wlast      (M_AXI_WLAST),
        .wready     (M_AXI_WREADY),
        .bresp      (M_AXI_BRESP),
        .bvalid     (M_AXI_BVALID),
        .bready     (M_AXI_BREADY)
    );

    initial begin
        M_AXI_ACLK = 1'b0;
        forever #2 M_AXI_ACLK = ~M_AXI_ACLK;   // 4 ns period
    end

    // Run limit
    always @(posedge M_AXI_ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Expected beat, same address rule as the source memory
    function automatic dma_pkg::data_t src_word(input dma_pkg::addr_t a);
        return {a ^ 32'h5a3c_96e1, a ^ 32'h5a3c_96e1};
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // --------------------
    // One copy job, start to done
    // --------------------
    task automatic run_job(input string name, input dma_pkg::addr_t src,
                           input dma_pkg::addr_t dst, input dma_pkg::len_t len,
                           input logic stalls, input int bad_beat, input logic bad_b);
        int beats;
        beats = 0;
        @(posedge M_AXI_ACLK);
        start     <= 1'b1;
        src_addr  <= src;
        dst_addr  <= dst;
        burst_len <= len;
        stall_en  <= stalls;
        err_beat  <= bad_beat;
        b_err     <= bad_b;
        @(posedge M_AXI_ACLK);
        start <= 1'b0;
        @(negedge M_AXI_ACLK);                  // Accepted on the last edge
        check_value({name, " busy"}, 64'd1, 64'(busy));
        check_value({name, " done cleared"}, 64'd0, 64'(done));
        check_value({name, " error cleared"}, 64'd0, 64'(error));
        check_value({name, " arvalid"}, 64'd1, 64'(M_AXI_ARVALID));
        check_value({name, " awvalid"}, 64'd1, 64'(M_AXI_AWVALID));
        check_value({name, " araddr"}, 64'(src), 64'(M_AXI_ARADDR));
        check_value({name, " arlen"}, 64'(len), 64'(M_AXI_ARLEN));
        check_value({name, " awaddr"}, 64'(dst), 64'(M_AXI_AWADDR));
        check_value({name, " awlen"}, 64'(len), 64'(M_AXI_AWLEN));
        // Watch every W handshake until done
        while (!done) begin
            if (M_AXI_WVALID && M_AXI_WREADY) begin
                check_value({name, " wlast"}, 64'(beats == int'(len)), 64'(M_AXI_WLAST));
                check_value({name, " data"}, src_word(src + 32'(beats * 8)), M_AXI_WDATA);
                beats++;
            end
            check_value({name, " irq before done"}, 64'd0, 64'(irq));
            @(negedge M_AXI_ACLK);
        end
        check_value({name, " irq with done"}, 64'd1, 64'(irq));
        check_value({name, " error at done"}, 64'(bad_beat >= 0 || bad_b), 64'(error));
        check_value({name, " W beat count"}, 64'(int'(len) + 1), 64'(beats));
        // irq single cycle, done held
        repeat (3) begin
            @(negedge M_AXI_ACLK);
            check_value({name, " irq after done"}, 64'd0, 64'(irq));
            check_value({name, " done held"}, 64'd1, 64'(done));
        end
    endtask

    initial begin
        rst       = 1'b1;
        start     = 1'b0;
        src_addr  = '0;
        dst_addr  = '0;
        burst_len = '0;
        stall_en  = 1'b0;
        err_beat  = -1;
        b_err     = 1'b0;
        repeat (8) @(posedge M_AXI_ACLK);
        rst <= 1'b0;
        @(negedge M_AXI_ACLK);
        // --------------------
        // Idle state out of reset
        // --------------------
        check_value("reset arvalid", 64'd0, 64'(M_AXI_ARVALID));
        check_value("reset awvalid", 64'd0, 64'(M_AXI_AWVALID));
        check_value("reset wvalid", 64'd0, 64'(M_AXI_WVALID));
        check_value("reset rready", 64'd0, 64'(M_AXI_RREADY));
        check_value("reset bready", 64'd0, 64'(M_AXI_BREADY));
        check_value("reset busy", 64'd0, 64'(busy));
        check_value("reset done", 64'd0, 64'(done));
        check_value("reset irq", 64'd0, 64'(irq));
        check_value("reset error", 64'd0, 64'(error));
        check_value("arsize", 64'd3, 64'(M_AXI_ARSIZE));        // 8-byte beats
        check_value("awsize", 64'd3, 64'(M_AXI_AWSIZE));
        check_value("arburst", 64'd1, 64'(M_AXI_ARBURST));      // INCR
        check_value("awburst", 64'd1, 64'(M_AXI_AWBURST));
        check_value("wstrb", 64'hff, 64'(M_AXI_WSTRB));

        run_job("short copy", 32'h0000_1000, 32'h0008_0000, 8'd3, 1'b0, -1, 1'b0);
        run_job("long copy", 32'h0000_2200, 32'h0009_0000, 8'd31, 1'b1, -1, 1'b0);
        run_job("read error", 32'h0000_4000, 32'h000a_0000, 8'd7, 1'b1, 5, 1'b0);
        run_job("write error", 32'h0000_6000, 32'h000b_0000, 8'd5, 1'b1, -1, 1'b1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
logic/dma_pkg.sv
logic/copy_control.sv
logic/burst_reader.sv
logic/beat_fifo.sv
logic/burst_writer.sv
logic/dma_copy_top.sv
testbench/axi_mem_model.sv
testbench/tb_dma_copy.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_dma_copy -o tb_dma_copy
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_dma_copy > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0
